// File: rtl/rv_decode_cfg.svh
`ifndef RV_DECODE_CFG_SVH
`define RV_DECODE_CFG_SVH

// Instruction and immediate width
`define RV_XLEN 32

// Register address width for 32 architectural registers
`define RV_REG_AW 5

`endif

// File: rtl/rv_decode_pkg.sv
package rv_decode_pkg;

    // Major opcodes that the decode stage recognises
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_BRANCH = 7'b1100011,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111
    } opcode_e;

    typedef enum logic [2:0] {
        FMT_R       = 3'd0,
        FMT_I       = 3'd1,
        FMT_S       = 3'd2,
        FMT_B       = 3'd3,
        FMT_U       = 3'd4,
        FMT_J       = 3'd5,
        FMT_ILLEGAL = 3'd7
    } fmt_e;

    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_AND  = 4'd2,
        ALU_OR   = 4'd3,
        ALU_XOR  = 4'd4,
        ALU_SLL  = 4'd5,
        ALU_SRL  = 4'd6,
        ALU_SRA  = 4'd7,
        ALU_SLTU = 4'd8,
        ALU_NONE = 4'hf
    } alu_op_e;

    typedef enum logic [1:0] {
        ALU_IN2_ZERO = 2'd0,
        ALU_IN2_RS2  = 2'd1,
        ALU_IN2_IMM  = 2'd2
    } alu_in2_e;

    typedef enum logic [2:0] {
        CMP_EQ   = 3'd0,
        CMP_NE   = 3'd1,
        CMP_LT   = 3'd2,
        CMP_GE   = 3'd3,
        CMP_LTU  = 3'd4,
        CMP_GEU  = 3'd5,
        CMP_NONE = 3'd6
    } cmp_op_e;

    // What the address adder computes
    typedef enum logic [2:0] {
        ADDER_NONE       = 3'd0,
        ADDER_EA         = 3'd1,
        ADDER_PC_REL     = 3'd2,
        ADDER_BR_TARGET  = 3'd3,
        ADDER_IND_TARGET = 3'd4,
        ADDER_J_TARGET   = 3'd5
    } adder_use_e;

    typedef enum logic [1:0] {
        ADD_IN1_ZERO = 2'd0,
        ADD_IN1_RS1  = 2'd1,
        ADD_IN1_PC   = 2'd2
    } add_in1_e;

    typedef enum logic [2:0] {
        WB_NONE       = 3'd0,
        WB_ALU        = 3'd1,
        WB_IMM        = 3'd2,
        WB_ADDER      = 3'd3,
        WB_LOAD       = 3'd4,
        WB_LOAD_ZEXT8 = 3'd5,
        WB_PC_PLUS4   = 3'd6
    } wb_sel_e;

    typedef enum logic [2:0] {
        IMM_NONE  = 3'd0,
        IMM_I     = 3'd1,
        IMM_SHAMT = 3'd2,
        IMM_S     = 3'd3,
        IMM_B     = 3'd4,
        IMM_U     = 3'd5,
        IMM_J     = 3'd6
    } imm_kind_e;

endpackage

// File: rtl/imm_gen.sv
`include "rv_decode_cfg.svh"
`timescale 1ns/1ns

module imm_gen import rv_decode_pkg::*; (
    input  logic [`RV_XLEN-1:0] instr_i,
    input  imm_kind_e           kind_i,
    output logic [`RV_XLEN-1:0] imm_o
);

    logic               sign;
    logic [`RV_XLEN-1:0] imm_i;
    logic [`RV_XLEN-1:0] imm_s;
    logic [`RV_XLEN-1:0] imm_b;
    logic [`RV_XLEN-1:0] imm_u;
    logic [`RV_XLEN-1:0] imm_j;
    logic [`RV_XLEN-1:0] imm_shamt;

    assign sign = instr_i[31];

    assign imm_i = {{(`RV_XLEN-12){sign}}, instr_i[31:20]};
    assign imm_s = {{(`RV_XLEN-12){sign}}, instr_i[31:25], instr_i[11:7]};
    assign imm_b = {{(`RV_XLEN-12){sign}}, instr_i[7], instr_i[30:25],
                    instr_i[11:8], 1'b0};   // Bit 0 always zero
    assign imm_u = {instr_i[31:12], 12'b0};
    assign imm_j = {{(`RV_XLEN-20){sign}}, instr_i[19:12], instr_i[20],
                    instr_i[30:21], 1'b0};
    assign imm_shamt = {{(`RV_XLEN-5){1'b0}}, instr_i[24:20]};   // Zero extended

    always_comb begin
        case (kind_i)
            IMM_I:     imm_o = imm_i;
            IMM_SHAMT: imm_o = imm_shamt;
            IMM_S:     imm_o = imm_s;
            IMM_B:     imm_o = imm_b;
            IMM_U:     imm_o = imm_u;
            IMM_J:     imm_o = imm_j;
            default:   imm_o = '0;
        endcase
    end

endmodule

// File: rtl/alu_decode.sv
`include "rv_decode_cfg.svh"
`timescale 1ns/1ns

module alu_decode import rv_decode_pkg::*; (
    input  logic [`RV_XLEN-1:0] instr_i,
    output logic                hit_o,
    output fmt_e                fmt_o,
    output alu_op_e             alu_op_o,
    output alu_in2_e            alu_in2_o,
    output logic                rs2_used_o,
    output imm_kind_e           imm_kind_o
);

    logic [6:0] funct7;
    logic [2:0] funct3;

    assign funct7 = instr_i[31:25];
    assign funct3 = instr_i[14:12];

    always_comb begin
        hit_o      = 1'b0;
        fmt_o      = FMT_ILLEGAL;
        alu_op_o   = ALU_NONE;
        alu_in2_o  = ALU_IN2_ZERO;
        rs2_used_o = 1'b0;
        imm_kind_o = IMM_NONE;

        case (instr_i[6:0])
            OPC_OP: begin
                case ({funct7, funct3})
                    {7'b0000000, 3'b000}: alu_op_o = ALU_ADD;
                    {7'b0100000, 3'b000}: alu_op_o = ALU_SUB;
                    {7'b0000000, 3'b111}: alu_op_o = ALU_AND;
                    {7'b0000000, 3'b110}: alu_op_o = ALU_OR;
                    {7'b0000000, 3'b100}: alu_op_o = ALU_XOR;
                    {7'b0000000, 3'b001}: alu_op_o = ALU_SLL;
                    {7'b0000000, 3'b101}: alu_op_o = ALU_SRL;
                    {7'b0100000, 3'b101}: alu_op_o = ALU_SRA;
                    {7'b0000000, 3'b011}: alu_op_o = ALU_SLTU;
                    default: ;
                endcase
                if (alu_op_o != ALU_NONE) begin
                    hit_o      = 1'b1;
                    fmt_o      = FMT_R;
                    alu_in2_o  = ALU_IN2_RS2;
                    rs2_used_o = 1'b1;
                end
            end

            OPC_OP_IMM: begin
                imm_kind_o = IMM_I;
                case (funct3)
                    3'b000: alu_op_o = ALU_ADD;
                    3'b111: alu_op_o = ALU_AND;
                    3'b110: alu_op_o = ALU_OR;
                    3'b100: alu_op_o = ALU_XOR;
                    3'b001: begin
                        if (funct7 == 7'b0000000) alu_op_o = ALU_SLL;
                        imm_kind_o = IMM_SHAMT;
                    end
                    3'b101: begin
                        if (funct7 == 7'b0000000) alu_op_o = ALU_SRL;
                        else if (funct7 == 7'b0100000) alu_op_o = ALU_SRA;
                        imm_kind_o = IMM_SHAMT;
                    end
                    default: ;
                endcase
                if (alu_op_o != ALU_NONE) begin
                    hit_o     = 1'b1;
                    fmt_o     = FMT_I;
                    alu_in2_o = ALU_IN2_IMM;
                end else begin
                    imm_kind_o = IMM_NONE;   // Back to default on a miss
                end
            end

            default: ;
        endcase
    end

endmodule

// File: rtl/xfer_decode.sv
`include "rv_decode_cfg.svh"
`timescale 1ns/1ns

module xfer_decode import rv_decode_pkg::*; (
    input  logic [`RV_XLEN-1:0] instr_i,
    output logic                hit_o,
    output fmt_e                fmt_o,
    output logic                rs1_used_o,
    output logic                rs2_used_o,
    output logic                rd_write_o,
    output cmp_op_e             cmp_op_o,
    output adder_use_e          adder_use_o,
    output add_in1_e            add_in1_o,
    output logic                add_postproc_o,
    output wb_sel_e             wb_sel_o,
    output logic                mem_read_o,
    output logic                mem_write_o,
    output logic [3:0]          mem_wstrb_o,
    output imm_kind_e           imm_kind_o
);

    logic [2:0] funct3;

    assign funct3 = instr_i[14:12];

    always_comb begin
        hit_o          = 1'b0;
        fmt_o          = FMT_ILLEGAL;
        rs1_used_o     = 1'b0;
        rs2_used_o     = 1'b0;
        rd_write_o     = 1'b0;
        cmp_op_o       = CMP_NONE;
        adder_use_o    = ADDER_NONE;
        add_in1_o      = ADD_IN1_ZERO;
        add_postproc_o = 1'b0;
        wb_sel_o       = WB_NONE;
        mem_read_o     = 1'b0;
        mem_write_o    = 1'b0;
        mem_wstrb_o    = 4'b0000;
        imm_kind_o     = IMM_NONE;

        case (instr_i[6:0])
            OPC_LUI: begin
                hit_o      = 1'b1;
                fmt_o      = FMT_U;
                rd_write_o = 1'b1;
                wb_sel_o   = WB_IMM;
                imm_kind_o = IMM_U;
            end

            OPC_AUIPC: begin
                hit_o       = 1'b1;
                fmt_o       = FMT_U;
                rd_write_o  = 1'b1;
                adder_use_o = ADDER_PC_REL;
                add_in1_o   = ADD_IN1_PC;
                wb_sel_o    = WB_ADDER;
                imm_kind_o  = IMM_U;
            end

            OPC_LOAD: begin
                if (funct3 == 3'b010 || funct3 == 3'b100) begin   // lw, lbu
                    hit_o       = 1'b1;
                    fmt_o       = FMT_I;
                    rs1_used_o  = 1'b1;
                    rd_write_o  = 1'b1;
                    adder_use_o = ADDER_EA;
                    add_in1_o   = ADD_IN1_RS1;
                    mem_read_o  = 1'b1;
                    wb_sel_o    = funct3[2] ? WB_LOAD_ZEXT8 : WB_LOAD;
                    imm_kind_o  = IMM_I;
                end
            end

            OPC_STORE: begin
                if (funct3 == 3'b010) begin   // sw only
                    hit_o       = 1'b1;
                    fmt_o       = FMT_S;
                    rs1_used_o  = 1'b1;
                    rs2_used_o  = 1'b1;
                    adder_use_o = ADDER_EA;
                    add_in1_o   = ADD_IN1_RS1;
                    mem_write_o = 1'b1;
                    mem_wstrb_o = 4'b1111;
                    imm_kind_o  = IMM_S;
                end
            end

            OPC_BRANCH: begin
                case (funct3)
                    3'b000: cmp_op_o = CMP_EQ;
                    3'b001: cmp_op_o = CMP_NE;
                    3'b100: cmp_op_o = CMP_LT;
                    3'b101: cmp_op_o = CMP_GE;
                    3'b110: cmp_op_o = CMP_LTU;
                    3'b111: cmp_op_o = CMP_GEU;
                    default: ;
                endcase
                if (cmp_op_o != CMP_NONE) begin
                    hit_o       = 1'b1;
                    fmt_o       = FMT_B;
                    rs1_used_o  = 1'b1;
                    rs2_used_o  = 1'b1;
                    adder_use_o = ADDER_BR_TARGET;
                    add_in1_o   = ADD_IN1_PC;
                    imm_kind_o  = IMM_B;
                end
            end

            OPC_JAL: begin
                hit_o       = 1'b1;
                fmt_o       = FMT_J;
                rd_write_o  = 1'b1;
                adder_use_o = ADDER_J_TARGET;
                add_in1_o   = ADD_IN1_PC;
                wb_sel_o    = WB_PC_PLUS4;
                imm_kind_o  = IMM_J;
            end

            OPC_JALR: begin
                if (funct3 == 3'b000) begin
                    hit_o          = 1'b1;
                    fmt_o          = FMT_I;
                    rs1_used_o     = 1'b1;
                    rd_write_o     = 1'b1;
                    adder_use_o    = ADDER_IND_TARGET;
                    add_in1_o      = ADD_IN1_RS1;
                    add_postproc_o = 1'b1;   // Target bit 0 cleared
                    wb_sel_o       = WB_PC_PLUS4;
                    imm_kind_o     = IMM_I;
                end
            end

            default: ;
        endcase
    end

endmodule

// File: rtl/decode_stage.sv
`include "rv_decode_cfg.svh"
`timescale 1ns/1ns

module decode_stage import rv_decode_pkg::*; (
    input  logic                  clk_i,
    input  logic                  reset_i,
    input  logic                  in_valid_i,
    output logic                  in_ready_o,
    input  logic [`RV_XLEN-1:0]   instr_i,
    output logic                  out_valid_o,
    input  logic                  out_ready_i,
    output logic                  illegal_o,
    output fmt_e                  fmt_o,
    output logic [`RV_REG_AW-1:0] rs1_addr_o,
    output logic [`RV_REG_AW-1:0] rs2_addr_o,
    output logic [`RV_REG_AW-1:0] rd_addr_o,
    output logic                  rs1_used_o,
    output logic                  rs2_used_o,
    output logic                  wb_en_o,
    output alu_op_e               alu_op_o,
    output alu_in2_e              alu_in2_o,
    output cmp_op_e               cmp_op_o,
    output adder_use_e            adder_use_o,
    output add_in1_e              add_in1_o,
    output logic                  add_postproc_o,
    output wb_sel_e               wb_sel_o,
    output logic                  mem_read_o,
    output logic                  mem_write_o,
    output logic [3:0]            mem_wstrb_o,
    output logic [`RV_XLEN-1:0]   imm_o
);

    logic                  alu_hit;
    fmt_e                  alu_fmt;
    alu_op_e               alu_op;
    alu_in2_e              alu_in2;
    logic                  alu_rs2_used;
    imm_kind_e             alu_imm_kind;

    logic                  x_hit;
    fmt_e                  x_fmt;
    logic                  x_rs1_used;
    logic                  x_rs2_used;
    logic                  x_rd_write;
    cmp_op_e               x_cmp_op;
    adder_use_e            x_adder_use;
    add_in1_e              x_add_in1;
    logic                  x_add_postproc;
    wb_sel_e               x_wb_sel;
    logic                  x_mem_read;
    logic                  x_mem_write;
    logic [3:0]            x_mem_wstrb;
    imm_kind_e             x_imm_kind;

    logic [`RV_REG_AW-1:0] rd_addr;
    imm_kind_e             sel_imm_kind;
    logic [`RV_XLEN-1:0]   imm;
    fmt_e                  sel_fmt;
    logic                  sel_rd_write;
    logic                  load;

    alu_decode i_alu_decode (
        .instr_i    (instr_i),
        .hit_o      (alu_hit),
        .fmt_o      (alu_fmt),
        .alu_op_o   (alu_op),
        .alu_in2_o  (alu_in2),
        .rs2_used_o (alu_rs2_used),
        .imm_kind_o (alu_imm_kind)
    );

    xfer_decode i_xfer_decode (
        .instr_i        (instr_i),
        .hit_o          (x_hit),
        .fmt_o          (x_fmt),
        .rs1_used_o     (x_rs1_used),
        .rs2_used_o     (x_rs2_used),
        .rd_write_o     (x_rd_write),
        .cmp_op_o       (x_cmp_op),
        .adder_use_o    (x_adder_use),
        .add_in1_o      (x_add_in1),
        .add_postproc_o (x_add_postproc),
        .wb_sel_o       (x_wb_sel),
        .mem_read_o     (x_mem_read),
        .mem_write_o    (x_mem_write),
        .mem_wstrb_o    (x_mem_wstrb),
        .imm_kind_o     (x_imm_kind)
    );

    imm_gen i_imm_gen (
        .instr_i (instr_i),
        .kind_i  (sel_imm_kind),
        .imm_o   (imm)
    );

    assign rd_addr      = instr_i[7 +: `RV_REG_AW];
    assign sel_imm_kind = alu_hit ? alu_imm_kind : x_imm_kind;
    assign sel_fmt      = alu_hit ? alu_fmt : (x_hit ? x_fmt : FMT_ILLEGAL);
    assign sel_rd_write = alu_hit | x_rd_write;   // All ALU ops write rd

    // Accept when the register is empty or drains this cycle
    assign in_ready_o = !out_valid_o || out_ready_i;
    assign load       = in_valid_i && in_ready_o;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            out_valid_o <= 1'b0;
        end else if (in_ready_o) begin
            out_valid_o <= in_valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            illegal_o      <= 1'b1;
            fmt_o          <= FMT_ILLEGAL;
            rs1_addr_o     <= '0;
            rs2_addr_o     <= '0;
            rd_addr_o      <= '0;
            rs1_used_o     <= 1'b0;
            rs2_used_o     <= 1'b0;
            wb_en_o        <= 1'b0;
            alu_op_o       <= ALU_NONE;
            alu_in2_o      <= ALU_IN2_ZERO;
            cmp_op_o       <= CMP_NONE;
            adder_use_o    <= ADDER_NONE;
            add_in1_o      <= ADD_IN1_ZERO;
            add_postproc_o <= 1'b0;
            wb_sel_o       <= WB_NONE;
            mem_read_o     <= 1'b0;
            mem_write_o    <= 1'b0;
            mem_wstrb_o    <= 4'b0000;
            imm_o          <= '0;
        end else if (load) begin
            illegal_o      <= !(alu_hit || x_hit);
            fmt_o          <= sel_fmt;
            rs1_addr_o     <= instr_i[15 +: `RV_REG_AW];
            rs2_addr_o     <= instr_i[20 +: `RV_REG_AW];
            rd_addr_o      <= rd_addr;
            rs1_used_o     <= alu_hit | x_rs1_used;
            rs2_used_o     <= alu_rs2_used | x_rs2_used;
            wb_en_o        <= sel_rd_write && (rd_addr != '0);   // x0 never written
            alu_op_o       <= alu_op;
            alu_in2_o      <= alu_in2;
            cmp_op_o       <= x_cmp_op;
            adder_use_o    <= x_adder_use;
            add_in1_o      <= x_add_in1;
            add_postproc_o <= x_add_postproc;
            wb_sel_o       <= alu_hit ? WB_ALU : x_wb_sel;
            mem_read_o     <= x_mem_read;
            mem_write_o    <= x_mem_write;
            mem_wstrb_o    <= x_mem_wstrb;
            imm_o          <= imm;
        end
    end

endmodule

// File: dv/tb_clkgen.sv
`timescale 1ns/1ns

module tb_clkgen (
    output logic clk_o,
    output logic reset_o
);

    initial begin
        clk_o = 1'b0;
        forever #5 clk_o = ~clk_o;   // 10 ns period
    end

    initial begin
        reset_o = 1'b1;
        repeat (2) @(posedge clk_o);
        #1;
        reset_o = 1'b0;   // Released with the other inputs
    end

endmodule

// File: dv/tb_decode_stage.sv
`include "rv_decode_cfg.svh"
`timescale 1ns/1ns

module tb_decode_stage import rv_decode_pkg::*; ();

    localparam int MAX_VECS   = 64;
    localparam int WAIT_LIMIT = 200;   // Cycles allowed per wait

    logic                  clk;
    logic                  reset;
    logic                  in_valid;
    logic                  in_ready;
    logic [`RV_XLEN-1:0]   instr;
    logic                  out_valid;
    logic                  out_ready;
    logic                  illegal;
    fmt_e                  fmt;
    logic [`RV_REG_AW-1:0] rs1_addr;
    logic [`RV_REG_AW-1:0] rs2_addr;
    logic [`RV_REG_AW-1:0] rd_addr;
    logic                  rs1_used;
    logic                  rs2_used;
    logic                  wb_en;
    alu_op_e               alu_op;
    alu_in2_e              alu_in2;
    cmp_op_e               cmp_op;
    adder_use_e            adder_use;
    add_in1_e              add_in1;
    logic                  add_postproc;
    wb_sel_e               wb_sel;
    logic                  mem_read;
    logic                  mem_write;
    logic [3:0]            mem_wstrb;
    logic [`RV_XLEN-1:0]   imm;

    // Record holds instr in [99:68], one nibble per field and imm in [31:0]
    logic [99:0] vec_mem [0:MAX_VECS-1];
    logic [99:0] exp_q [$];
    logic [99:0] drive_rec;
    logic [77:0] out_bundle;
    logic [77:0] held;
    logic        accepted_last;
    logic        stalled_last;
    logic [31:0] lfsr;
    int          value_errs;
    int          other_errs;
    int          outputs_seen;
    logic        timed_out;

    tb_clkgen i_clkgen (
        .clk_o   (clk),
        .reset_o (reset)
    );

    decode_stage i_dut (
        .clk_i (clk), .reset_i (reset),
        .in_valid_i (in_valid), .in_ready_o (in_ready), .instr_i (instr),
        .out_valid_o (out_valid), .out_ready_i (out_ready),
        .illegal_o (illegal), .fmt_o (fmt),
        .rs1_addr_o (rs1_addr), .rs2_addr_o (rs2_addr), .rd_addr_o (rd_addr),
        .rs1_used_o (rs1_used), .rs2_used_o (rs2_used), .wb_en_o (wb_en),
        .alu_op_o (alu_op), .alu_in2_o (alu_in2), .cmp_op_o (cmp_op),
        .adder_use_o (adder_use), .add_in1_o (add_in1), .add_postproc_o (add_postproc),
        .wb_sel_o (wb_sel), .mem_read_o (mem_read), .mem_write_o (mem_write),
        .mem_wstrb_o (mem_wstrb), .imm_o (imm)
    );

    assign out_bundle = {illegal, fmt, rs1_addr, rs2_addr, rd_addr, rs1_used, rs2_used,
                         wb_en, alu_op, alu_in2, cmp_op, adder_use, add_in1,
                         add_postproc, wb_sel, mem_read, mem_write, mem_wstrb, imm};

    function automatic logic [31:0] lfsr_step(input logic [31:0] state);
        logic [31:0] next;
        next = state >> 1;
        if (state[0]) begin
            next = next ^ 32'h80200003;   // x^32 + x^22 + x^2 + x + 1
        end
        return next;
    endfunction

    task automatic check_bit(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            value_errs++;
            $display("error at time %0t: %s expected %0b, got %0b", $time, what, exp, got);
        end
    endtask

    task automatic check_fmt(input fmt_e got, input fmt_e exp, input string what);
        if (got !== exp) begin
            value_errs++;
            $display("error at time %0t: %s fmt expected %s, got %s (%0d)",
                     $time, what, exp.name(), got.name(), got);
        end
    endtask

    task automatic check_alu(input alu_op_e got, input alu_op_e exp, input string what);
        if (got !== exp) begin
            value_errs++;
            $display("error at time %0t: %s alu_op expected %s, got %s (%0d)",
                     $time, what, exp.name(), got.name(), got);
        end
    endtask

    task automatic check_alu_in2(input alu_in2_e got, input alu_in2_e exp, input string what);
        if (got !== exp) begin
            value_errs++;
            $display("error at time %0t: %s alu_in2 expected %s, got %s (%0d)",
                     $time, what, exp.name(), got.name(), got);
        end
    endtask

    task automatic check_cmp(input cmp_op_e got, input cmp_op_e exp, input string what);
        if (got !== exp) begin
            value_errs++;
            $display("error at time %0t: %s cmp_op expected %s, got %s (%0d)",
                     $time, what, exp.name(), got.name(), got);
        end
    endtask

    task automatic check_adder(input adder_use_e got, input adder_use_e exp, input string what);
        if (got !== exp) begin
            value_errs++;
            $display("error at time %0t: %s adder_use expected %s, got %s (%0d)",
                     $time, what, exp.name(), got.name(), got);
        end
    endtask

    task automatic check_add_in1(input add_in1_e got, input add_in1_e exp, input string what);
        if (got !== exp) begin
            value_errs++;
            $display("error at time %0t: %s add_in1 expected %s, got %s (%0d)",
                     $time, what, exp.name(), got.name(), got);
        end
    endtask

    task automatic check_wb(input wb_sel_e got, input wb_sel_e exp, input string what);
        if (got !== exp) begin
            value_errs++;
            $display("error at time %0t: %s wb_sel expected %s, got %s (%0d)",
                     $time, what, exp.name(), got.name(), got);
        end
    endtask

    task automatic check_addr(input logic [`RV_REG_AW-1:0] got,
                              input logic [`RV_REG_AW-1:0] exp, input string what);
        if (got !== exp) begin
            value_errs++;
            $display("error at time %0t: %s expected x%0d, got x%0d", $time, what, exp, got);
        end
    endtask

    task automatic check_strb(input logic [3:0] got, input logic [3:0] exp, input string what);
        if (got !== exp) begin
            value_errs++;
            $display("error at time %0t: %s mem_wstrb expected %04b, got %04b",
                     $time, what, exp, got);
        end
    endtask

    task automatic check_imm(input logic [`RV_XLEN-1:0] got, input logic [`RV_XLEN-1:0] exp,
                             input string what);
        if (got !== exp) begin
            value_errs++;
            $display("error at time %0t: %s imm expected %08h, got %08h", $time, what, exp, got);
        end
    endtask

    task automatic compare_outputs(input logic [99:0] rec);
        string      tag;
        fmt_e       exp_fmt;
        alu_op_e    exp_alu;
        alu_in2_e   exp_in2;
        adder_use_e exp_adder;
        add_in1_e   exp_in1;
        logic       exp_legal;
        logic       exp_rs1_used;
        logic       exp_rs2_used;
        logic       exp_mw;
        tag       = $sformatf("instr %08h", rec[99:68]);
        exp_legal = !rec[64];
        exp_fmt   = fmt_e'(rec[62:60]);
        exp_alu   = alu_op_e'(rec[59:56]);
        exp_adder = adder_use_e'(rec[50:48]);
        exp_mw    = rec[36];
        // R ops take rs2, I ops the immediate
        if (exp_alu == ALU_NONE) begin
            exp_in2 = ALU_IN2_ZERO;
        end else if (exp_fmt == FMT_R) begin
            exp_in2 = ALU_IN2_RS2;
        end else begin
            exp_in2 = ALU_IN2_IMM;
        end
        case (exp_adder)
            ADDER_EA, ADDER_IND_TARGET:                    exp_in1 = ADD_IN1_RS1;
            ADDER_PC_REL, ADDER_BR_TARGET, ADDER_J_TARGET: exp_in1 = ADD_IN1_PC;
            default:                                       exp_in1 = ADD_IN1_ZERO;
        endcase
        // Only the U and J formats have no rs1 field
        exp_rs1_used = exp_legal && exp_fmt != FMT_U && exp_fmt != FMT_J;
        exp_rs2_used = exp_fmt == FMT_R || exp_fmt == FMT_S || exp_fmt == FMT_B;
        check_bit(illegal, rec[64], {tag, " illegal"});
        check_fmt(fmt, exp_fmt, tag);
        check_alu(alu_op, exp_alu, tag);
        check_alu_in2(alu_in2, exp_in2, tag);
        check_cmp(cmp_op, cmp_op_e'(rec[54:52]), tag);
        check_adder(adder_use, exp_adder, tag);
        check_add_in1(add_in1, exp_in1, tag);
        check_bit(add_postproc, exp_adder == ADDER_IND_TARGET, {tag, " add_postproc"});
        check_wb(wb_sel, wb_sel_e'(rec[46:44]), tag);
        check_bit(mem_read, rec[40], {tag, " mem_read"});
        check_bit(mem_write, exp_mw, {tag, " mem_write"});
        check_strb(mem_wstrb, {4{exp_mw}}, tag);
        check_bit(wb_en, rec[32], {tag, " wb_en"});
        check_bit(rs1_used, exp_rs1_used, {tag, " rs1_used"});
        check_bit(rs2_used, exp_rs2_used, {tag, " rs2_used"});
        check_addr(rs1_addr, rec[87:83], {tag, " rs1_addr"});
        check_addr(rs2_addr, rec[92:88], {tag, " rs2_addr"});
        check_addr(rd_addr, rec[79:75], {tag, " rd_addr"});
        check_imm(imm, rec[31:0], tag);
    endtask

    // Random back-pressure from one LFSR bit per cycle
    always @(posedge clk) begin
        #1;
        out_ready = lfsr[0];
        lfsr      = lfsr_step(lfsr);
    end

    always @(posedge clk) begin
        if (!reset) begin
            if (accepted_last) begin
                check_bit(out_valid, 1'b1, "out_valid one cycle after accept");
            end
            if (stalled_last) begin
                check_bit(out_valid, 1'b1, "out_valid held while stalled");
                check_bit(out_bundle == held, 1'b1, "outputs held while stalled");
            end
            if (out_valid && out_ready) begin
                if (exp_q.size() == 0) begin
                    other_errs++;
                    $display("DUT delivered a result at time %0t with no input pending", $time);
                end else begin
                    outputs_seen++;
                    compare_outputs(exp_q.pop_front());
                end
            end
            if (in_valid && in_ready) begin
                exp_q.push_back(drive_rec);
            end
            accepted_last = in_valid && in_ready;
            stalled_last  = out_valid && !out_ready;
            held          = out_bundle;
        end
    end

    initial begin
        int i;
        int n_vecs;
        int waited;
        in_valid      = 1'b0;
        instr         = '0;
        out_ready     = 1'b0;
        drive_rec     = '0;
        held          = '0;
        accepted_last = 1'b0;
        stalled_last  = 1'b0;
        lfsr          = 32'h3d5ed1e6;
        value_errs    = 0;
        other_errs    = 0;
        outputs_seen  = 0;
        timed_out     = 1'b0;

        // Unused slots get an illegal-field nibble of f, which ends the list
        for (i = 0; i < MAX_VECS; i++) begin
            vec_mem[i] = {32'(i), 4'hf, 64'h0};
        end
        $readmemh("dv/decode_tests.txt", vec_mem);
        n_vecs = 0;
        while (n_vecs < MAX_VECS && vec_mem[n_vecs][67:64] <= 4'h1) begin
            n_vecs++;
        end
        if (n_vecs == 0) begin
            other_errs++;
            $display("No test vectors were read from dv/decode_tests.txt");
        end

        @(posedge clk);
        waited = 0;
        while (reset && waited < WAIT_LIMIT) begin
            @(posedge clk);
            waited++;
        end
        #1;
        if (reset) begin
            other_errs++;
            timed_out = 1'b1;
            $display("Timeout: reset was never released");
        end else begin
            check_bit(out_valid, 1'b0, "out_valid after reset");
            check_bit(in_ready, 1'b1, "in_ready after reset");
        end

        for (i = 0; i < n_vecs && !timed_out; i++) begin
            in_valid  = 1'b1;
            instr     = vec_mem[i][99:68];
            drive_rec = vec_mem[i];
            waited    = 0;
            @(posedge clk);
            while (!in_ready && waited < WAIT_LIMIT) begin
                @(posedge clk);
                waited++;
            end
            if (!in_ready) begin
                other_errs++;
                timed_out = 1'b1;
                $display("Timeout: instruction %08h was not accepted in %0d cycles",
                         instr, WAIT_LIMIT);
            end
            #1;
        end
        in_valid = 1'b0;

        waited = 0;
        while (!timed_out && exp_q.size() != 0 && waited < WAIT_LIMIT) begin
            @(posedge clk);
            #1;
            waited++;
        end
        if (exp_q.size() != 0) begin
            other_errs++;
            $display("Timeout: %0d results never left the DUT", exp_q.size());
        end
        if (!timed_out && outputs_seen != n_vecs) begin
            other_errs++;
            $display("Sent %0d instructions but received %0d results", n_vecs, outputs_seen);
        end
        repeat (3) @(posedge clk);   // Catch stray results
        #1;

        $display("value errors: %0d, other errors: %0d", value_errs, other_errs);
        if (value_errs == 0 && other_errs == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// File: dv/decode_tests.txt
// instr_illegal_fmt_aluop_cmpop_adderuse_wbsel_memrd_memwr_wben_imm
// Field codes are the rv_decode_pkg enum values, e.g. fmt 7 illegal, alu f none
003100b3_0_0_0_6_0_1_0_0_1_00000000  // add x1, x2, x3
407302b3_0_0_1_6_0_1_0_0_1_00000000  // sub x5, x6, x7
00c5f533_0_0_2_6_0_1_0_0_1_00000000  // and x10, x11, x12
0020e033_0_0_3_6_0_1_0_0_0_00000000  // or x0, x1, x2
005241b3_0_0_4_6_0_1_0_0_1_00000000  // xor x3, x4, x5
00a49433_0_0_5_6_0_1_0_0_1_00000000  // sll x8, x9, x10
003150b3_0_0_6_6_0_1_0_0_1_00000000  // srl x1, x2, x3
403150b3_0_0_7_6_0_1_0_0_1_00000000  // sra x1, x2, x3
0062b233_0_0_8_6_0_1_0_0_1_00000000  // sltu x4, x5, x6
fff10093_0_1_0_6_0_1_0_0_1_ffffffff  // addi x1, x2, -1
7ff27193_0_1_2_6_0_1_0_0_1_000007ff  // andi x3, x4, 2047
80036293_0_1_3_6_0_1_0_0_1_fffff800  // ori x5, x6, -2048
0050c013_0_1_4_6_0_1_0_0_0_00000005  // xori x0, x1, 5
01f41393_0_1_5_6_0_1_0_0_1_0000001f  // slli x7, x8, 31
00455493_0_1_6_6_0_1_0_0_1_00000004  // srli x9, x10, 4
41f65593_0_1_7_6_0_1_0_0_1_0000001f  // srai x11, x12, 31
123452b7_0_4_f_6_0_2_0_0_1_12345000  // lui x5, 0x12345
fffff037_0_4_f_6_0_2_0_0_0_fffff000  // lui x0, 0xfffff
80000097_0_4_f_6_2_3_0_0_1_80000000  // auipc x1, 0x80000
001000ef_0_5_f_6_5_6_0_0_1_00000800  // jal x1, +2048
ffdff06f_0_5_f_6_5_6_0_0_0_fffffffc  // jal x0, -4
008100e7_0_1_f_6_4_6_0_0_1_00000008  // jalr x1, 8(x2)
ff83a303_0_1_f_6_1_4_1_0_1_fffffff8  // lw x6, -8(x7)
0034c403_0_1_f_6_1_5_1_0_1_00000003  // lbu x8, 3(x9)
fea5ae23_0_2_f_6_1_0_0_1_0_fffffffc  // sw x10, -4(x11)
00208863_0_3_f_0_3_0_0_0_0_00000010  // beq x1, x2, +16
fe419fe3_0_3_f_1_3_0_0_0_0_fffffffe  // bne x3, x4, -2
0062c0e3_0_3_f_2_3_0_0_0_0_00000800  // blt x5, x6, +2048
8083d063_0_3_f_3_3_0_0_0_0_fffff000  // bge x7, x8, -4096
0220e063_0_3_f_4_3_0_0_0_0_00000020  // bltu x1, x2, +32
0020f263_0_3_f_5_3_0_0_0_0_00000004  // bgeu x1, x2, +4
003120b3_1_7_f_6_0_0_0_0_0_00000000  // slt is not kept
403110b3_1_7_f_6_0_0_0_0_0_00000000  // OP funct7 0x20 with funct3 1
40041393_1_7_f_6_0_0_0_0_0_00000000  // slli with funct7 0x20
00512093_1_7_f_6_0_0_0_0_0_00000000  // slti is not kept
008110e7_1_7_f_6_0_0_0_0_0_00000000  // jalr with funct3 1
00049403_1_7_f_6_0_0_0_0_0_00000000  // lh is not kept
00a58023_1_7_f_6_0_0_0_0_0_00000000  // sb is not kept
0020a263_1_7_f_6_0_0_0_0_0_00000000  // branch funct3 2
00000073_1_7_f_6_0_0_0_0_0_00000000  // ecall
00100073_1_7_f_6_0_0_0_0_0_00000000  // ebreak
0ff0000f_1_7_f_6_0_0_0_0_0_00000000  // fence
30200073_1_7_f_6_0_0_0_0_0_00000000  // mret
00000000_1_7_f_6_0_0_0_0_0_00000000  // all zeros
ffffffff_1_7_f_6_0_0_0_0_0_00000000  // all ones

// File: sources.f
+incdir+rtl
rtl/rv_decode_pkg.sv
rtl/imm_gen.sv
rtl/alu_decode.sv
rtl/xfer_decode.sv
rtl/decode_stage.sv
dv/tb_clkgen.sv
dv/tb_decode_stage.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the decode stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

TOP=tb_decode_stage
LOG=sim.log

verilator --binary --timing -f sources.f --top-module "$TOP" -o "V$TOP"
build_status=$?
if [ $build_status -ne 0 ]; then
    echo "Verilator build failed with status $build_status"
    exit 1
fi

"./obj_dir/V$TOP" > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
    echo "Simulation exited with status $run_status"
    exit 1
fi

if grep -q "TEST FAILED" "$LOG"; then
    echo "Simulation reported failure, see $LOG"
    exit 1
fi

exit 0
